// ==== hdl/isa_pkg.sv ====
// Instruction encoding for the decode and issue stage, imported by the decoders and register file
package isa_pkg;

   // Instruction and register file geometry
   localparam int insn_w = 32;
   localparam int reg_aw = 5;
   localparam int opc_w = 6;
   localparam int imm_w = 16;

   // Field positions
   localparam int opc_msb = 31;
   localparam int opc_lsb = 26;
   localparam int rd_msb = 25;
   localparam int rd_lsb = 21;
   localparam int rs1_msb = 20;
   localparam int rs1_lsb = 16;
   localparam int rs2_msb = 15;
   localparam int rs2_lsb = 11;

   // Immediate overlaps rs2 and is sign-extended by the decoder
   localparam int imm_msb = 15;
   localparam int imm_lsb = 0;

   // Register-register ALU group
   localparam logic [opc_w-1:0] op_add = 6'h01;
   localparam logic [opc_w-1:0] op_sub = 6'h02;
   localparam logic [opc_w-1:0] op_and = 6'h03;
   localparam logic [opc_w-1:0] op_or = 6'h04;
   localparam logic [opc_w-1:0] op_xor = 6'h05;
   localparam logic [opc_w-1:0] op_sll = 6'h06;
   localparam logic [opc_w-1:0] op_srl = 6'h07;

   // Register-immediate ALU
   localparam logic [opc_w-1:0] op_addi = 6'h08;

   // Multiplier
   localparam logic [opc_w-1:0] op_mul = 6'h10;

   // Load and store with address rs1 plus immediate
   localparam logic [opc_w-1:0] op_lw = 6'h18;
   localparam logic [opc_w-1:0] op_sw = 6'h19;

   // Branch and jump
   localparam logic [opc_w-1:0] op_beq = 6'h20;
   localparam logic [opc_w-1:0] op_jal = 6'h21;

   // System call is the last legal opcode
   localparam logic [opc_w-1:0] op_syscall = 6'h3f;

endpackage

// ==== hdl/issue_pkg.sv ====
// Micro-operation encoding carried from decode into the EX stage registers
package issue_pkg;

   // Functional unit classes
   localparam int fu_w = 3;

   typedef enum logic [fu_w-1:0] {
      fu_alu,
      fu_mul,
      fu_bru,
      fu_lsu,
      fu_epu
   } fu_e;

   // Operation within a unit
   localparam int op_w = 4;

   localparam logic [op_w-1:0] alu_add = 4'd0;
   localparam logic [op_w-1:0] alu_sub = 4'd1;
   localparam logic [op_w-1:0] alu_and = 4'd2;
   localparam logic [op_w-1:0] alu_or = 4'd3;
   localparam logic [op_w-1:0] alu_xor = 4'd4;
   localparam logic [op_w-1:0] alu_sll = 4'd5;
   localparam logic [op_w-1:0] alu_srl = 4'd6;
   localparam logic [op_w-1:0] mul_mul = 4'd0;
   localparam logic [op_w-1:0] bru_beq = 4'd0;
   localparam logic [op_w-1:0] bru_jal = 4'd1;
   localparam logic [op_w-1:0] lsu_lw = 4'd0;
   localparam logic [op_w-1:0] lsu_sw = 4'd1;

   // Exception and interrupt codes for the EPU
   localparam logic [op_w-1:0] epu_syscall = 4'd0;
   localparam logic [op_w-1:0] epu_illegal = 4'd1;
   localparam logic [op_w-1:0] epu_fetch_exc = 4'd2;
   localparam logic [op_w-1:0] epu_irq = 4'd3;

endpackage

// ==== hdl/insn_decoder.sv ====
// Combinational decoder for one issue slot, instantiated once per slot by the top level
`timescale 1ns/100ps

module insn_decoder
#(
   parameter DW = 32
)
(
   input  logic [isa_pkg::insn_w-1:0]  insn,
   input  logic                        exc,
   input  logic                        irq,
   output issue_pkg::fu_e              fu,
   output logic [issue_pkg::op_w-1:0]  op,
   output logic [DW-1:0]               imm,
   output logic                        rf_we,
   output logic [isa_pkg::reg_aw-1:0]  rd,
   output logic                        rs1_re,
   output logic                        rs2_re,
   output logic [isa_pkg::reg_aw-1:0]  rs1_addr,
   output logic [isa_pkg::reg_aw-1:0]  rs2_addr,
   output logic                        single_fu
);
   import isa_pkg::*;
   import issue_pkg::*;

   // Register use as {rf_we, rs1_re, rs2_re}
   localparam logic [2:0] use_rrr = 3'b111;
   localparam logic [2:0] use_rri = 3'b110;
   localparam logic [2:0] use_rr = 3'b011;
   localparam logic [2:0] use_w = 3'b100;
   localparam logic [2:0] use_none = 3'b000;

   logic [opc_w-1:0]   opc;
   logic               illegal;
   fu_e                dec_fu;
   logic [op_w-1:0]    dec_op;
   logic [2:0]         dec_use;

   assign opc = insn[opc_msb:opc_lsb];
   assign rd = insn[rd_msb:rd_lsb];
   assign rs1_addr = insn[rs1_msb:rs1_lsb];
   assign rs2_addr = insn[rs2_msb:rs2_lsb];
   assign imm = {{(DW-imm_w){insn[imm_msb]}}, insn[imm_msb:imm_lsb]};

   // Opcode table
   always_comb
   begin
      illegal = 1'b0;
      dec_fu = fu_alu;
      dec_op = alu_add;
      dec_use = use_rrr;
      case (opc)
         op_add: dec_op = alu_add;
         op_sub: dec_op = alu_sub;
         op_and: dec_op = alu_and;
         op_or: dec_op = alu_or;
         op_xor: dec_op = alu_xor;
         op_sll: dec_op = alu_sll;
         op_srl: dec_op = alu_srl;
         op_addi: dec_use = use_rri;
         op_mul: dec_fu = fu_mul;
         op_lw:
         begin
            dec_fu = fu_lsu;
            dec_op = lsu_lw;
            dec_use = use_rri;
         end
         op_sw:
         begin
            // Store data comes through the rs2 port
            dec_fu = fu_lsu;
            dec_op = lsu_sw;
            dec_use = use_rr;
         end
         op_beq:
         begin
            dec_fu = fu_bru;
            dec_op = bru_beq;
            dec_use = use_rr;
         end
         op_jal:
         begin
            // Link register only
            dec_fu = fu_bru;
            dec_op = bru_jal;
            dec_use = use_w;
         end
         op_syscall:
         begin
            dec_fu = fu_epu;
            dec_op = epu_syscall;
            dec_use = use_none;
         end
         default:
            illegal = 1'b1;
      endcase
   end

   // Fetch exception wins over interrupt, interrupt over illegal opcode
   always_comb
   begin
      fu = dec_fu;
      op = dec_op;
      {rf_we, rs1_re, rs2_re} = dec_use;
      if (exc || irq || illegal)
      begin
         fu = fu_epu;
         {rf_we, rs1_re, rs2_re} = use_none;
         if (exc)
            op = epu_fetch_exc;
         else if (irq)
            op = epu_irq;
         else
            op = epu_illegal;
      end
   end

   // One copy each of MUL, LSU and EPU
   assign single_fu = (fu == fu_mul) || (fu == fu_lsu) || (fu == fu_epu);

endmodule

// ==== hdl/regfile.sv ====
// Architectural register file with registered read ports, two per slot, and one writeback port
`timescale 1ns/100ps

module regfile
#(
   parameter P_ISSUE_WIDTH = 1,
   parameter DW = 32
)
(
   input  logic                                           clk,
   input  logic                                           reset,
   input  logic [2*(1<<P_ISSUE_WIDTH)-1:0]                re,
   input  logic [isa_pkg::insn_w*(1<<P_ISSUE_WIDTH)-1:0]  ins,
   input  logic                                           we,
   input  logic [isa_pkg::reg_aw-1:0]                     waddr,
   input  logic [DW-1:0]                                  wdata,
   output logic [2*DW*(1<<P_ISSUE_WIDTH)-1:0]             rdata
);
   import isa_pkg::*;

   localparam int IW = 1 << P_ISSUE_WIDTH;
   localparam int n_regs = 1 << reg_aw;

   logic [DW-1:0]      regs [n_regs];
   logic [reg_aw-1:0]  raddr [2*IW];

   // Port 2*i reads rs1 of slot i, port 2*i+1 reads rs2
   always_comb
   begin
      for (int i = 0; i < IW; i++)
      begin
         raddr[2*i] = ins[i*insn_w + rs1_lsb +: reg_aw];
         raddr[2*i+1] = ins[i*insn_w + rs2_lsb +: reg_aw];
      end
   end

   // Register 0 is never written, so it stays zero after reset
   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         for (int r = 0; r < n_regs; r++)
            regs[r] <= '0;
      end
      else if (we && (waddr != '0))
         regs[waddr] <= wdata;
   end

   // Read data holds while its enable is low
   always_ff @(posedge clk)
   begin
      for (int p = 0; p < 2*IW; p++)
      begin
         if (re[p])
            rdata[p*DW +: DW] <= regs[raddr[p]];
      end
   end

endmodule

// ==== hdl/issue_select.sv ====
// Issue selection for a decoded group, with the pop count back to the frontend and EX registers
`timescale 1ns/100ps

module issue_select
#(
   parameter P_ISSUE_WIDTH = 1,
   parameter DW = 32
)
(
   input  logic                                              clk,
   input  logic                                              reset,
   input  logic                                              stall,
   input  logic                                              flush,
   // Frontend
   input  logic [(1<<P_ISSUE_WIDTH)-1:0]                     id_valid,
   input  logic [DW*(1<<P_ISSUE_WIDTH)-1:0]                  id_pc,
   output logic [P_ISSUE_WIDTH:0]                            id_pop_cnt,
   // Decoder array
   input  logic [issue_pkg::fu_w*(1<<P_ISSUE_WIDTH)-1:0]     fu,
   input  logic [issue_pkg::op_w*(1<<P_ISSUE_WIDTH)-1:0]     op,
   input  logic [DW*(1<<P_ISSUE_WIDTH)-1:0]                  imm,
   input  logic [(1<<P_ISSUE_WIDTH)-1:0]                     rf_we,
   input  logic [isa_pkg::reg_aw*(1<<P_ISSUE_WIDTH)-1:0]     rd,
   input  logic [(1<<P_ISSUE_WIDTH)-1:0]                     rs1_re,
   input  logic [isa_pkg::reg_aw*(1<<P_ISSUE_WIDTH)-1:0]     rs1_addr,
   input  logic [(1<<P_ISSUE_WIDTH)-1:0]                     rs2_re,
   input  logic [isa_pkg::reg_aw*(1<<P_ISSUE_WIDTH)-1:0]     rs2_addr,
   input  logic [(1<<P_ISSUE_WIDTH)-1:0]                     single_fu,
   // Register file read enables
   output logic [2*(1<<P_ISSUE_WIDTH)-1:0]                   arf_re,
   // EX stage
   output logic [(1<<P_ISSUE_WIDTH)-1:0]                     ex_valid,
   output logic [issue_pkg::fu_w*(1<<P_ISSUE_WIDTH)-1:0]     ex_fu,
   output logic [issue_pkg::op_w*(1<<P_ISSUE_WIDTH)-1:0]     ex_op,
   output logic [DW*(1<<P_ISSUE_WIDTH)-1:0]                  ex_imm,
   output logic [DW*(1<<P_ISSUE_WIDTH)-1:0]                  ex_pc,
   output logic [isa_pkg::reg_aw*(1<<P_ISSUE_WIDTH)-1:0]     ex_rd,
   output logic [(1<<P_ISSUE_WIDTH)-1:0]                     ex_rf_we
);
   import isa_pkg::*;
   import issue_pkg::*;

   localparam int IW = 1 << P_ISSUE_WIDTH;

   logic                   p_ce;
   logic [IW-1:0]          raw_dep;
   logic [IW-1:0]          issue_msk;
   logic [IW-1:0]          issue_valid;
   logic [P_ISSUE_WIDTH:0] issue_cnt;

   assign p_ce = ~stall;

   // Slot k depends on an earlier slot j of the group that writes one of its sources
   always_comb
   begin
      raw_dep = '0;
      for (int k = 1; k < IW; k++)
      begin
         for (int j = 0; j < k; j++)
         begin
            if (rf_we[j] &&
                ((rs1_re[k] && (rs1_addr[k*reg_aw +: reg_aw] == rd[j*reg_aw +: reg_aw])) ||
                 (rs2_re[k] && (rs2_addr[k*reg_aw +: reg_aw] == rd[j*reg_aw +: reg_aw]))))
               raw_dep[k] = 1'b1;
         end
      end
   end

   // The first blocked slot ends the group
   always_comb
   begin
      issue_msk[0] = 1'b1;
      for (int i = 1; i < IW; i++)
         issue_msk[i] = issue_msk[i-1] & ~single_fu[i] & ~raw_dep[i];
   end

   assign issue_valid = issue_msk & id_valid;

   // Both vectors are contiguous from slot 0, so a plain bit count is the leading count
   always_comb
   begin
      issue_cnt = '0;
      for (int i = 0; i < IW; i++)
         issue_cnt = issue_cnt + issue_valid[i];
   end

   assign id_pop_cnt = p_ce ? issue_cnt : '0;

   always_comb
   begin
      for (int i = 0; i < IW; i++)
      begin
         arf_re[2*i] = p_ce & rs1_re[i];
         arf_re[2*i+1] = p_ce & rs2_re[i];
      end
   end

   // Flush clears the group even during a stall
   always_ff @(posedge clk)
   begin
      if (reset || flush)
         ex_valid <= '0;
      else if (p_ce)
         ex_valid <= issue_valid;
   end

   always_ff @(posedge clk)
   begin
      if (p_ce)
      begin
         ex_fu <= fu;
         ex_op <= op;
         ex_imm <= imm;
         ex_pc <= id_pc;
         ex_rd <= rd;
         ex_rf_we <= rf_we;
      end
   end

endmodule

// ==== hdl/decode_issue.sv ====
// Top level of the decode and issue stage, wiring decoders, register file and issue selector
`timescale 1ns/100ps

module decode_issue
#(
   parameter P_ISSUE_WIDTH = 1,
   parameter DW = 32
)
(
   input  logic                                              clk,
   input  logic                                              reset,
   input  logic                                              stall,
   input  logic                                              flush,
   // Frontend
   input  logic [(1<<P_ISSUE_WIDTH)-1:0]                     id_valid,
   input  logic [isa_pkg::insn_w*(1<<P_ISSUE_WIDTH)-1:0]     id_ins,
   input  logic [DW*(1<<P_ISSUE_WIDTH)-1:0]                  id_pc,
   input  logic [(1<<P_ISSUE_WIDTH)-1:0]                     id_exc,
   input  logic                                              id_irq,
   output logic [P_ISSUE_WIDTH:0]                            id_pop_cnt,
   // Writeback
   input  logic                                              wb_we,
   input  logic [isa_pkg::reg_aw-1:0]                        wb_addr,
   input  logic [DW-1:0]                                     wb_data,
   // EX stage
   output logic [(1<<P_ISSUE_WIDTH)-1:0]                     ex_valid,
   output logic [issue_pkg::fu_w*(1<<P_ISSUE_WIDTH)-1:0]     ex_fu,
   output logic [issue_pkg::op_w*(1<<P_ISSUE_WIDTH)-1:0]     ex_op,
   output logic [DW*(1<<P_ISSUE_WIDTH)-1:0]                  ex_imm,
   output logic [DW*(1<<P_ISSUE_WIDTH)-1:0]                  ex_pc,
   output logic [isa_pkg::reg_aw*(1<<P_ISSUE_WIDTH)-1:0]     ex_rd,
   output logic [(1<<P_ISSUE_WIDTH)-1:0]                     ex_rf_we,
   output logic [DW*(1<<P_ISSUE_WIDTH)-1:0]                  ex_operand1,
   output logic [DW*(1<<P_ISSUE_WIDTH)-1:0]                  ex_operand2
);
   import isa_pkg::*;
   import issue_pkg::*;

   localparam int IW = 1 << P_ISSUE_WIDTH;

   logic [fu_w*IW-1:0]     dec_fu;
   logic [op_w*IW-1:0]     dec_op;
   logic [DW*IW-1:0]       dec_imm;
   logic [IW-1:0]          dec_rf_we;
   logic [reg_aw*IW-1:0]   dec_rd;
   logic [IW-1:0]          dec_rs1_re;
   logic [reg_aw*IW-1:0]   dec_rs1_addr;
   logic [IW-1:0]          dec_rs2_re;
   logic [reg_aw*IW-1:0]   dec_rs2_addr;
   logic [IW-1:0]          dec_single_fu;
   logic [2*IW-1:0]        arf_re;
   logic [2*DW*IW-1:0]     arf_rdata;

   genvar i;

   generate
      for (i = 0; i < IW; i = i + 1)
      begin : gen_dec
         // Interrupt is taken on slot 0 only
         insn_decoder #(.DW(DW)) u_dec
         (
            .insn       (id_ins[i*insn_w +: insn_w]),
            .exc        (id_exc[i]),
            .irq        ((i == 0) ? id_irq : 1'b0),
            .fu         (dec_fu[i*fu_w +: fu_w]),
            .op         (dec_op[i*op_w +: op_w]),
            .imm        (dec_imm[i*DW +: DW]),
            .rf_we      (dec_rf_we[i]),
            .rd         (dec_rd[i*reg_aw +: reg_aw]),
            .rs1_re     (dec_rs1_re[i]),
            .rs2_re     (dec_rs2_re[i]),
            .rs1_addr   (dec_rs1_addr[i*reg_aw +: reg_aw]),
            .rs2_addr   (dec_rs2_addr[i*reg_aw +: reg_aw]),
            .single_fu  (dec_single_fu[i])
         );

         // Read port 2*i feeds operand 1, port 2*i+1 feeds operand 2
         assign ex_operand1[i*DW +: DW] = arf_rdata[2*i*DW +: DW];
         assign ex_operand2[i*DW +: DW] = arf_rdata[(2*i+1)*DW +: DW];
      end
   endgenerate

   regfile #(.P_ISSUE_WIDTH(P_ISSUE_WIDTH), .DW(DW)) u_arf
   (
      .clk     (clk),
      .reset   (reset),
      .re      (arf_re),
      .ins     (id_ins),
      .we      (wb_we),
      .waddr   (wb_addr),
      .wdata   (wb_data),
      .rdata   (arf_rdata)
   );

   issue_select #(.P_ISSUE_WIDTH(P_ISSUE_WIDTH), .DW(DW)) u_sel
   (
      .clk         (clk),
      .reset       (reset),
      .stall       (stall),
      .flush       (flush),
      .id_valid    (id_valid),
      .id_pc       (id_pc),
      .id_pop_cnt  (id_pop_cnt),
      .fu          (dec_fu),
      .op          (dec_op),
      .imm         (dec_imm),
      .rf_we       (dec_rf_we),
      .rd          (dec_rd),
      .rs1_re      (dec_rs1_re),
      .rs1_addr    (dec_rs1_addr),
      .rs2_re      (dec_rs2_re),
      .rs2_addr    (dec_rs2_addr),
      .single_fu   (dec_single_fu),
      .arf_re      (arf_re),
      .ex_valid    (ex_valid),
      .ex_fu       (ex_fu),
      .ex_op       (ex_op),
      .ex_imm      (ex_imm),
      .ex_pc       (ex_pc),
      .ex_rd       (ex_rd),
      .ex_rf_we    (ex_rf_we)
   );

endmodule

// ==== verif/tb_issue_model.svh ====
// Reference model of the decode and issue stage, included inside the testbench module body
`ifndef TB_ISSUE_MODEL_SVH
`define TB_ISSUE_MODEL_SVH

// Architectural register contents as seen by the EX stage
logic [DW-1:0] shadow [1 << reg_aw];

// Expected decode packed as {fu[9:7], op[6:3], rf_we[2], rs1_re[1], rs2_re[0]}
function automatic logic [9:0] decode_expect(input logic [insn_w-1:0] ins, input logic exc,
                                             input logic irq);
   logic [opc_w-1:0] opc;
   logic [2:0] f;
   logic [3:0] o;
   logic bad;
   logic we;
   logic r1;
   logic r2;
   opc = ins[opc_msb:opc_lsb];
   bad = 1'b0;
   f = fu_epu;
   case (opc)
      op_add, op_sub, op_and, op_or, op_xor, op_sll, op_srl, op_addi: f = fu_alu;
      op_mul: f = fu_mul;
      op_beq, op_jal: f = fu_bru;
      op_lw, op_sw: f = fu_lsu;
      op_syscall: f = fu_epu;
      default: bad = 1'b1;
   endcase
   // Add, mul, beq and lw all use operation zero of their unit
   case (opc)
      op_sub: o = alu_sub;
      op_and: o = alu_and;
      op_or: o = alu_or;
      op_xor: o = alu_xor;
      op_sll: o = alu_sll;
      op_srl: o = alu_srl;
      op_sw: o = lsu_sw;
      op_jal: o = bru_jal;
      op_syscall: o = epu_syscall;
      default: o = 4'd0;
   endcase
   we = (opc != op_sw) && (opc != op_beq) && (opc != op_syscall);
   r1 = (opc != op_jal) && (opc != op_syscall);
   r2 = r1 && (opc != op_addi) && (opc != op_lw);
   // Fetch exception first, then interrupt, then illegal opcode
   if (exc || irq || bad)
   begin
      o = exc ? epu_fetch_exc : (irq ? epu_irq : epu_illegal);
      return {3'(fu_epu), o, 3'b000};
   end
   return {f, o, we, r1, r2};
endfunction

function automatic logic single_unit(input logic [2:0] f);
   return (f == fu_mul) || (f == fu_lsu) || (f == fu_epu);
endfunction

// Slot k reads register r through one of its enabled source ports
function automatic logic reads_reg(input int k, input logic [reg_aw-1:0] r);
   logic [insn_w-1:0] ins;
   ins = id_ins[k*insn_w +: insn_w];
   return (cur_dec[k][1] && (ins[rs1_msb:rs1_lsb] == r)) ||
          (cur_dec[k][0] && (ins[rs2_msb:rs2_lsb] == r));
endfunction

// Leading slots that may issue together
function automatic logic [IW-1:0] issue_mask_expect();
   logic [IW-1:0] m;
   logic hazard;
   m = '0;
   for (int k = 0; k < IW; k++)
   begin
      hazard = single_unit(cur_dec[k][9:7]);
      for (int j = 0; j < k; j++)
      begin
         if (cur_dec[j][2] && reads_reg(k, id_ins[j*insn_w + rd_lsb +: reg_aw]))
            hazard = 1'b1;
      end
      if (k == 0)
         m[k] = 1'b1;
      else
         m[k] = m[k-1] && !hazard;
   end
   return m;
endfunction

`endif

// ==== verif/tb_decode_issue.sv ====
// Testbench for the decode and issue stage that checks random instruction groups against a model
`timescale 1ns/100ps

module tb_decode_issue;
   import isa_pkg::*;
   import issue_pkg::*;

   localparam int PIW = 1;
   localparam int IW = 1 << PIW;
   localparam int DW = 32;
   localparam int n_random = 3000;
   localparam int drain_limit = 50;

   logic clk;
   logic reset;
   logic stall;
   logic flush;
   logic [IW-1:0] id_valid;
   logic [insn_w*IW-1:0] id_ins;
   logic [DW*IW-1:0] id_pc;
   logic [IW-1:0] id_exc;
   logic id_irq;
   logic [PIW:0] id_pop_cnt;
   logic wb_we;
   logic [reg_aw-1:0] wb_addr;
   logic [DW-1:0] wb_data;
   logic [IW-1:0] ex_valid;
   logic [fu_w*IW-1:0] ex_fu;
   logic [op_w*IW-1:0] ex_op;
   logic [DW*IW-1:0] ex_imm;
   logic [DW*IW-1:0] ex_pc;
   logic [reg_aw*IW-1:0] ex_rd;
   logic [IW-1:0] ex_rf_we;
   logic [DW*IW-1:0] ex_operand1;
   logic [DW*IW-1:0] ex_operand2;

   integer seed;
   int n_checks;
   int n_val_err;
   int n_other_err;
   int pre_addr;
   int stall_left;
   int cur_pop;

   // Instructions offered by the frontend, oldest first
   logic [insn_w-1:0] q_ins [$];
   logic [DW-1:0] q_pc [$];
   logic q_exc [$];
   logic [DW-1:0] next_pc;

   logic [9:0] cur_dec [IW];
   logic [IW-1:0] cur_iv;
   logic [IW-1:0] exp_valid;
   logic [9:0] exp_dec [IW];
   logic [insn_w-1:0] exp_ins [IW];
   logic [DW-1:0] exp_pc [IW];
   logic ex_known;
   logic [DW-1:0] exp_opd [2*IW];
   logic opd_known [2*IW];
   logic [opc_w-1:0] opc_tab [14];

   `include "tb_issue_model.svh"

   decode_issue #(.P_ISSUE_WIDTH(PIW), .DW(DW)) dut0 (.*);

   initial clk = 1'b0;
   always #4 clk = ~clk;

   task automatic check_value(input string name, input int slot, input logic [63:0] got,
                              input logic [63:0] exp);
      n_checks++;
      assert (got === exp)
      else
      begin
         n_val_err++;
         $display("** Error %s[%0d]: got %h, expected %h", name, slot, got, exp);
      end
   endtask

   // Small register span in random mode to provoke RAW pairs
   function automatic logic [insn_w-1:0] random_insn(input int reg_span);
      logic [insn_w-1:0] ins;
      ins = $random(seed);
      if (($random(seed) & 7) != 0)
         ins[opc_msb:opc_lsb] = opc_tab[$unsigned($random(seed)) % 14];
      ins[rd_msb:rd_lsb] = $unsigned($random(seed)) % reg_span;
      ins[rs1_msb:rs1_lsb] = $unsigned($random(seed)) % reg_span;
      ins[rs2_msb:rs2_lsb] = $unsigned($random(seed)) % reg_span;
      return ins;
   endfunction

   task automatic push_insn(input logic [insn_w-1:0] ins, input logic exc);
      q_ins.push_back(ins);
      q_pc.push_back(next_pc);
      q_exc.push_back(exc);
      next_pc = next_pc + 4;
   endtask

   // Mode 0 preload, 1 single add, 2 random groups, 3 drain
   task automatic drive_inputs(input int mode);
      logic [insn_w-1:0] ins;
      stall = 1'b0;
      flush = 1'b0;
      id_irq = 1'b0;
      wb_we = (mode == 0);
      wb_addr = (mode == 0) ? pre_addr : $random(seed);
      wb_data = $random(seed);
      if (mode == 1 && q_ins.size() == 0)
      begin
         ins = random_insn(32);
         ins[opc_msb:opc_lsb] = op_add;
         // rs1 walks up and rs2 walks down through the register file
         ins[rs1_msb:rs1_lsb] = reg_aw'(pre_addr);
         ins[rs2_msb:rs2_lsb] = reg_aw'(~pre_addr);
         push_insn(ins, 1'b0);
      end
      if (mode == 2)
      begin
         for (int s = 0; s < IW; s++)
         begin
            if (q_ins.size() < IW && ($random(seed) & 3) != 0)
               push_insn(random_insn(8), ($random(seed) & 15) == 0);
         end
         if (stall_left == 0 && ($random(seed) & 15) == 0)
            stall_left = 1 + $unsigned($random(seed)) % 6;
         stall = (stall_left > 0);
         if (stall_left > 0)
            stall_left--;
         flush = ($unsigned($random(seed)) % 20) == 0;
         id_irq = ($unsigned($random(seed)) % 12) == 0;
         wb_we = $random(seed) & 1;
      end
      for (int s = 0; s < IW; s++)
      begin
         id_valid[s] = (s < q_ins.size());
         id_ins[s*insn_w +: insn_w] = id_valid[s] ? q_ins[s] : $random(seed);
         id_pc[s*DW +: DW] = id_valid[s] ? q_pc[s] : '0;
         id_exc[s] = id_valid[s] ? q_exc[s] : 1'b0;
      end
   endtask

   task automatic evaluate_inputs();
      for (int s = 0; s < IW; s++)
         cur_dec[s] = decode_expect(id_ins[s*insn_w +: insn_w], id_exc[s], (s == 0) && id_irq);
      cur_iv = issue_mask_expect() & id_valid;
      cur_pop = 0;
      for (int s = 0; s < IW; s++)
         cur_pop = cur_pop + cur_iv[s];
      if (stall)
         cur_pop = 0;
   endtask

   // Model view of the clock edge with the inputs that were stable across it
   task automatic update_model();
      logic [insn_w-1:0] ins;
      for (int s = 0; s < IW; s++)
      begin
         ins = id_ins[s*insn_w +: insn_w];
         if (!stall && cur_dec[s][1])
         begin
            exp_opd[2*s] = shadow[ins[rs1_msb:rs1_lsb]];
            opd_known[2*s] = 1'b1;
         end
         if (!stall && cur_dec[s][0])
         begin
            exp_opd[2*s+1] = shadow[ins[rs2_msb:rs2_lsb]];
            opd_known[2*s+1] = 1'b1;
         end
         if (!stall)
         begin
            exp_dec[s] = cur_dec[s];
            exp_ins[s] = ins;
            exp_pc[s] = id_pc[s*DW +: DW];
         end
      end
      if (flush)
         exp_valid = '0;
      else if (!stall)
         exp_valid = cur_iv;
      if (!stall)
         ex_known = 1'b1;
      // Frontend removes as many instructions as the DUT accepted
      for (int k = 0; k < id_pop_cnt; k++)
      begin
         assert (q_ins.size() > 0)
         else
         begin
            n_other_err++;
            $display("DUT accepted more instructions than the frontend offered");
         end
         if (q_ins.size() > 0)
         begin
            void'(q_ins.pop_front());
            void'(q_pc.pop_front());
            void'(q_exc.pop_front());
         end
      end
      // Write lands after the read of the same edge
      if (wb_we && wb_addr != '0)
         shadow[wb_addr] = wb_data;
   endtask

   task automatic check_outputs();
      logic [insn_w-1:0] ins;
      logic [DW-1:0] imm_exp;
      check_value("ex_valid", 0, ex_valid, exp_valid);
      for (int s = 0; s < IW; s++)
      begin
         ins = exp_ins[s];
         // Low half of the instruction taken as a signed number
         imm_exp = $signed(ins[imm_msb:imm_lsb]);
         if (ex_known)
         begin
            check_value("ex_fu", s, ex_fu[s*fu_w +: fu_w], exp_dec[s][9:7]);
            check_value("ex_op", s, ex_op[s*op_w +: op_w], exp_dec[s][6:3]);
            check_value("ex_rf_we", s, ex_rf_we[s], exp_dec[s][2]);
            check_value("ex_imm", s, ex_imm[s*DW +: DW], imm_exp);
            check_value("ex_rd", s, ex_rd[s*reg_aw +: reg_aw], ins[rd_msb:rd_lsb]);
            check_value("ex_pc", s, ex_pc[s*DW +: DW], exp_pc[s]);
         end
         if (opd_known[2*s])
            check_value("ex_operand1", s, ex_operand1[s*DW +: DW], exp_opd[2*s]);
         if (opd_known[2*s+1])
            check_value("ex_operand2", s, ex_operand2[s*DW +: DW], exp_opd[2*s+1]);
      end
   endtask

   task automatic step_cycle(input int mode);
      @(posedge clk);
      update_model();
      #1;
      check_outputs();
      drive_inputs(mode);
      evaluate_inputs();
      #1;
      check_value("id_pop_cnt", 0, id_pop_cnt, cur_pop);
   endtask

   task automatic drain_queue();
      int waited;
      waited = 0;
      while (q_ins.size() > 0 && waited < drain_limit)
      begin
         step_cycle(3);
         waited++;
      end
      if (q_ins.size() > 0)
      begin
         n_other_err++;
         $display("Frontend queue did not drain within %0d cycles", drain_limit);
      end
      // Last group reaches the EX registers
      step_cycle(3);
   endtask

   initial
   begin
      seed = 65;
      reset = 1'b1;
      stall = 1'b0;
      flush = 1'b0;
      id_valid = '0;
      id_ins = '0;
      id_pc = '0;
      id_exc = '0;
      id_irq = 1'b0;
      wb_we = 1'b0;
      wb_addr = '0;
      wb_data = '0;
      n_checks = 0;
      n_val_err = 0;
      n_other_err = 0;
      stall_left = 0;
      next_pc = 32'h1000;
      exp_valid = '0;
      ex_known = 1'b0;
      for (int p = 0; p < 2*IW; p++)
         opd_known[p] = 1'b0;
      for (int r = 0; r < (1 << reg_aw); r++)
         shadow[r] = '0;
      opc_tab = '{op_add, op_sub, op_and, op_or, op_xor, op_sll, op_srl, op_addi,
                  op_mul, op_lw, op_sw, op_beq, op_jal, op_syscall};
      repeat (8) @(posedge clk);
      #1;
      reset = 1'b0;
      evaluate_inputs();
      for (pre_addr = 1; pre_addr < (1 << reg_aw); pre_addr++)
         step_cycle(0);
      // Single reg-reg adds sweep both source ports over all registers including zero
      for (pre_addr = 0; pre_addr < 64; pre_addr++)
         step_cycle(1);
      repeat (n_random) step_cycle(2);
      drain_queue();
      $display("Checks: %0d, value errors: %0d, other errors: %0d",
               n_checks, n_val_err, n_other_err);
      if (n_val_err == 0 && n_other_err == 0)
         $display("STATUS: PASS");
      else
         $display("STATUS: FAIL");
      $finish;
   end

endmodule

// ==== sources.f ====
+incdir+verif
hdl/isa_pkg.sv
hdl/issue_pkg.sv
hdl/insn_decoder.sv
hdl/regfile.sv
hdl/issue_select.sv
hdl/decode_issue.sv
verif/tb_decode_issue.sv

// ==== Bender.yml ====
package:
  name: decode_issue

sources:
  # Packages before the modules that import them
  - hdl/isa_pkg.sv
  - hdl/issue_pkg.sv
  - hdl/insn_decoder.sv
  - hdl/regfile.sv
  - hdl/issue_select.sv
  - hdl/decode_issue.sv
  - target: simulation
    include_dirs:
      - verif
    files:
      - verif/tb_decode_issue.sv
